/* rv_isa_pkg.sv */
package rv_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction fields seen by the controller
    //////////////////////////////////////////////////////////////////////

    typedef logic [6:0] opcode_t;   // instr[6:0]
    typedef logic [2:0] funct3_t;   // instr[14:12]

    //////////////////////////////////////////////////////////////////////
    // RV32I major opcodes
    //////////////////////////////////////////////////////////////////////

    localparam opcode_t OPC_RTYPE  = 7'b0110011;   // Register-register ALU
    localparam opcode_t OPC_ITYPE  = 7'b0010011;   // Register-immediate ALU
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    //////////////////////////////////////////////////////////////////////
    // Load/store access size in funct3
    //////////////////////////////////////////////////////////////////////

    // Stores only use the signed codes
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;

    // Zero-extending loads
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

endpackage

/* ctrl_pkg.sv */
package ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath select codes
    //////////////////////////////////////////////////////////////////////

    typedef logic [1:0] pc_sel_t;
    localparam pc_sel_t PC_NEXT   = 2'd0;   // PC + 4
    localparam pc_sel_t PC_BRANCH = 2'd1;   // PC + B-immediate
    localparam pc_sel_t PC_JAL    = 2'd2;   // PC + J-immediate
    localparam pc_sel_t PC_JALR   = 2'd3;   // rs1 + I-immediate

    typedef logic [1:0] wb_sel_t;
    localparam wb_sel_t WB_ALU  = 2'd0;     // ALU result
    localparam wb_sel_t WB_MEM  = 2'd1;     // Load data
    localparam wb_sel_t WB_LINK = 2'd2;     // Return address

    // One-hot: bit 0 byte, bit 1 half, bit 2 word
    typedef logic [2:0] mem_size_t;

    // Work an instruction hands to one of the execution units
    typedef enum logic [2:0] {
        CLASS_NONE,
        CLASS_REG,
        CLASS_IMM,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR
    } exec_class_t;

    // Control word driven to the datapath
    typedef struct packed {
        logic      ir_en;       // Instruction register load
        logic      pc_en;       // PC load
        pc_sel_t   pc_sel;
        logic      alu_src;     // ALU operand b from immediate
        logic      reg_write;
        wb_sel_t   wb_sel;
        mem_size_t mem_size;
        logic      mem_read;
        logic      mem_write;
    } ctrl_t;

    localparam ctrl_t CTRL_IDLE = '0;

endpackage

/* instr_sequencer.sv */
`timescale 1ns/1ps

module instr_sequencer
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  run,
    output logic                  instr_done,
    input  rv_isa_pkg::opcode_t   opcode,
    output ctrl_pkg::exec_class_t exec_class,
    output logic                  rw_req,
    output logic                  mem_req,
    output logic                  flow_req,
    input  logic                  rw_ack,
    input  logic                  mem_ack,
    input  logic                  flow_ack,
    input  ctrl_pkg::ctrl_t       rw_ctrl,
    input  ctrl_pkg::ctrl_t       mem_ctrl,
    input  ctrl_pkg::ctrl_t       flow_ctrl,
    output ctrl_pkg::ctrl_t       ctrl
);

    import rv_isa_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, ADVANCE, DECODE, EXECUTE, RELEASE, DONE} state_t;

    state_t      state;
    state_t      state_next;
    exec_class_t decoded_class;     // Class of the opcode at the input
    logic        unit_ack;          // Ack from the unit owning exec_class
    ctrl_t       own_ctrl;          // Fetch and PC advance strobes

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (opcode)
            OPC_RTYPE:                     decoded_class = CLASS_REG;
            OPC_ITYPE, OPC_LUI, OPC_AUIPC: decoded_class = CLASS_IMM;
            OPC_LOAD:                      decoded_class = CLASS_LOAD;
            OPC_STORE:                     decoded_class = CLASS_STORE;
            OPC_BRANCH:                    decoded_class = CLASS_BRANCH;
            OPC_JAL:                       decoded_class = CLASS_JAL;
            OPC_JALR:                      decoded_class = CLASS_JALR;
            default:                       decoded_class = CLASS_NONE;  // Skips execution
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Main FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= IDLE;
            exec_class <= CLASS_NONE;
        end
        else
        begin
            state <= state_next;
            if (state == DECODE)
                exec_class <= decoded_class;    // Held until the next decode
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (run)
                    state_next = FETCH;
            FETCH:   state_next = ADVANCE;
            ADVANCE: state_next = DECODE;
            DECODE:  state_next = (decoded_class == CLASS_NONE) ? DONE : EXECUTE;
            EXECUTE:
                if (unit_ack)
                    state_next = RELEASE;
            RELEASE:
                if (!unit_ack)
                    state_next = DONE;
            DONE:
                if (!run)
                    state_next = IDLE;      // Back-pressure from the environment
            default: state_next = IDLE;
        endcase
    end

    always_comb
    begin
        case (exec_class)
            CLASS_REG, CLASS_IMM:                unit_ack = rw_ack;
            CLASS_LOAD, CLASS_STORE:             unit_ack = mem_ack;
            CLASS_BRANCH, CLASS_JAL, CLASS_JALR: unit_ack = flow_ack;
            default:                             unit_ack = 1'b0;
        endcase
    end

    // Req stays up until the unit acks
    assign rw_req   = (state == EXECUTE) && (exec_class inside {CLASS_REG, CLASS_IMM});
    assign mem_req  = (state == EXECUTE) && (exec_class inside {CLASS_LOAD, CLASS_STORE});
    assign flow_req = (state == EXECUTE) &&
                      (exec_class inside {CLASS_BRANCH, CLASS_JAL, CLASS_JALR});

    assign instr_done = (state == DONE);

    //////////////////////////////////////////////////////////////////////
    // Control word merge
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        own_ctrl       = CTRL_IDLE;
        own_ctrl.ir_en = (state == FETCH);
        own_ctrl.pc_en = (state == ADVANCE);    // pc_sel left at PC_NEXT
    end

    always_comb
    begin
        if (rw_req)
            ctrl = rw_ctrl;
        else if (mem_req)
            ctrl = mem_ctrl;
        else if (flow_req)
            ctrl = flow_ctrl;
        else
            ctrl = own_ctrl;
    end

    // Unit strobes must never overlap a fetch or an advance
    a_fetch_advance_apart: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.ir_en && ctrl.pc_en));

    a_single_req: assert property (@(posedge clk) disable iff (reset)
        $onehot0({rw_req, mem_req, flow_req}));

endmodule

/* reg_writeback_unit.sv */
`timescale 1ns/1ps

module reg_writeback_unit
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  ctrl_pkg::exec_class_t exec_class,
    output ctrl_pkg::ctrl_t       unit_ctrl
);

    import ctrl_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, WRITE, ACK} state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (req)
                    state_next = SETUP;
            SETUP: state_next = WRITE;
            WRITE: state_next = ACK;
            ACK:
                if (!req)
                    state_next = IDLE;  // Four-phase release
            default: state_next = IDLE;
        endcase
    end

    assign ack = (state == ACK);

    // Operand and writeback selects hold from setup until ack drops
    always_comb
    begin
        unit_ctrl = CTRL_IDLE;
        if (state != IDLE)
        begin
            unit_ctrl.alu_src   = (exec_class == CLASS_IMM);   // Immediate operand b
            unit_ctrl.wb_sel    = WB_ALU;
            unit_ctrl.reg_write = (state == WRITE);
        end
    end

    a_ack_under_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> req);

endmodule

/* mem_access_unit.sv */
`timescale 1ns/1ps

module mem_access_unit
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  ctrl_pkg::exec_class_t exec_class,
    input  rv_isa_pkg::funct3_t   funct3,
    output ctrl_pkg::ctrl_t       unit_ctrl
);

    import rv_isa_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [2:0] {IDLE, SETUP, ACCESS, WRITE, ACK} state_t;

    localparam mem_size_t SIZE_NONE = 3'b000;
    localparam mem_size_t SIZE_BYTE = 3'b001;
    localparam mem_size_t SIZE_HALF = 3'b010;
    localparam mem_size_t SIZE_WORD = 3'b100;

    state_t    state;
    state_t    state_next;
    mem_size_t req_size;    // Decoded from funct3, SIZE_NONE if unsupported
    mem_size_t size_q;
    logic      is_load;

    always_comb
    begin
        req_size = SIZE_NONE;
        if (exec_class == CLASS_LOAD)
        begin
            case (funct3)
                F3_BYTE, F3_BYTE_U: req_size = SIZE_BYTE;
                F3_HALF, F3_HALF_U: req_size = SIZE_HALF;
                F3_WORD:            req_size = SIZE_WORD;
                default:            req_size = SIZE_NONE;
            endcase
        end
        else if (exec_class == CLASS_STORE)
        begin
            case (funct3)
                F3_BYTE: req_size = SIZE_BYTE;
                F3_HALF: req_size = SIZE_HALF;
                F3_WORD: req_size = SIZE_WORD;
                default: req_size = SIZE_NONE;
            endcase
        end
    end

    // Capture the access at the start of the handshake
    always_ff @(posedge clk)
    begin
        if (state == IDLE && req)
        begin
            size_q  <= req_size;
            is_load <= (exec_class == CLASS_LOAD);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (req)
                    state_next = SETUP;
            SETUP:   state_next = (size_q == SIZE_NONE) ? ACK : ACCESS;  // No strobe if unsupported
            ACCESS:  state_next = is_load ? WRITE : ACK;
            WRITE:   state_next = ACK;
            ACK:
                if (!req)
                    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign ack = (state == ACK);

    always_comb
    begin
        unit_ctrl = CTRL_IDLE;
        if (state != IDLE)
        begin
            unit_ctrl.alu_src = 1'b1;                       // Address is rs1 + offset
            unit_ctrl.wb_sel  = is_load ? WB_MEM : WB_ALU;
        end
        if (state == ACCESS)
        begin
            unit_ctrl.mem_size  = size_q;
            unit_ctrl.mem_read  = is_load;
            unit_ctrl.mem_write = !is_load;
        end
        unit_ctrl.reg_write = (state == WRITE);             // Load data to rd
    end

    a_read_write_apart: assert property (@(posedge clk) disable iff (reset)
        !(unit_ctrl.mem_read && unit_ctrl.mem_write));

    a_size_onehot: assert property (@(posedge clk) disable iff (reset)
        (unit_ctrl.mem_read || unit_ctrl.mem_write) |-> $onehot(unit_ctrl.mem_size));

endmodule

/* flow_change_unit.sv */
`timescale 1ns/1ps

module flow_change_unit
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  ctrl_pkg::exec_class_t exec_class,
    input  logic                  comparator,
    output ctrl_pkg::ctrl_t       unit_ctrl
);

    import ctrl_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, REDIRECT, ACK} state_t;

    state_t state;
    state_t state_next;
    logic   taken;      // Branch outcome sampled with req
    logic   is_jump;

    assign is_jump = (exec_class == CLASS_JAL) || (exec_class == CLASS_JALR);

    always_ff @(posedge clk)
    begin
        if (state == IDLE && req)
            taken <= comparator;
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (req)
                    state_next = SETUP;
            SETUP:    state_next = REDIRECT;
            REDIRECT: state_next = ACK;     // Not-taken branch idles through here
            ACK:
                if (!req)
                    state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    assign ack = (state == ACK);

    always_comb
    begin
        unit_ctrl = CTRL_IDLE;
        // Link write path is set up early and held until ack drops
        if (state != IDLE && is_jump)
        begin
            unit_ctrl.wb_sel  = WB_LINK;
            unit_ctrl.alu_src = (exec_class == CLASS_JALR);    // rs1 + imm target
        end
        if (state == REDIRECT)
        begin
            case (exec_class)
                CLASS_BRANCH:
                begin
                    unit_ctrl.pc_en  = taken;
                    unit_ctrl.pc_sel = taken ? PC_BRANCH : PC_NEXT;
                end
                CLASS_JAL:
                begin
                    unit_ctrl.pc_en     = 1'b1;
                    unit_ctrl.pc_sel    = PC_JAL;
                    unit_ctrl.reg_write = 1'b1;
                end
                CLASS_JALR:
                begin
                    unit_ctrl.pc_en     = 1'b1;
                    unit_ctrl.pc_sel    = PC_JALR;
                    unit_ctrl.reg_write = 1'b1;
                end
                default:
                begin
                    unit_ctrl.pc_en = 1'b0;
                end
            endcase
        end
    end

    a_redirect_sel: assert property (@(posedge clk) disable iff (reset)
        unit_ctrl.pc_en |-> (unit_ctrl.pc_sel != PC_NEXT));

endmodule

/* cpu_controller.sv */
`timescale 1ns/1ps

module cpu_controller
(
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  rv_isa_pkg::opcode_t opcode,
    input  rv_isa_pkg::funct3_t funct3,
    input  logic                comparator,
    output ctrl_pkg::ctrl_t     ctrl,
    output logic                instr_done
);

    import ctrl_pkg::*;

    exec_class_t exec_class;
    logic        rw_req;
    logic        rw_ack;
    logic        mem_req;
    logic        mem_ack;
    logic        flow_req;
    logic        flow_ack;
    ctrl_t       rw_ctrl;
    ctrl_t       mem_ctrl;
    ctrl_t       flow_ctrl;

    instr_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .instr_done (instr_done),
        .opcode     (opcode),
        .exec_class (exec_class),
        .rw_req     (rw_req),
        .mem_req    (mem_req),
        .flow_req   (flow_req),
        .rw_ack     (rw_ack),
        .mem_ack    (mem_ack),
        .flow_ack   (flow_ack),
        .rw_ctrl    (rw_ctrl),
        .mem_ctrl   (mem_ctrl),
        .flow_ctrl  (flow_ctrl),
        .ctrl       (ctrl)
    );

    // R, I, LUI and AUIPC
    reg_writeback_unit u_rw (
        .clk        (clk),
        .reset      (reset),
        .req        (rw_req),
        .ack        (rw_ack),
        .exec_class (exec_class),
        .unit_ctrl  (rw_ctrl)
    );

    mem_access_unit u_mem (
        .clk        (clk),
        .reset      (reset),
        .req        (mem_req),
        .ack        (mem_ack),
        .exec_class (exec_class),
        .funct3     (funct3),
        .unit_ctrl  (mem_ctrl)
    );

    flow_change_unit u_flow (
        .clk        (clk),
        .reset      (reset),
        .req        (flow_req),
        .ack        (flow_ack),
        .exec_class (exec_class),
        .comparator (comparator),
        .unit_ctrl  (flow_ctrl)
    );

endmodule

/* tb_cpu_controller.sv */
`timescale 1ns/1ps

module tb_cpu_controller;

    import rv_isa_pkg::*;
    import ctrl_pkg::*;

    // Strobe counts and the selects seen with them over one instruction
    typedef struct packed {
        logic [7:0] ir_en;
        logic [7:0] pc_next;
        logic [7:0] pc_branch;
        logic [7:0] pc_jal;
        logic [7:0] pc_jalr;
        logic [7:0] reg_write;
        logic [7:0] mem_read;
        logic [7:0] mem_write;
        mem_size_t  mem_size;       // At the memory strobe
        logic       mem_alu_src;    // At the memory strobe
        wb_sel_t    wb_sel;         // At reg_write
        logic       wb_alu_src;     // At reg_write
    } strobe_rec_t;

    // Run rises 1 ns after an edge, so monitor cycle 1 is still idle
    localparam int FETCH_CYCLE   = 2;
    localparam int ADVANCE_CYCLE = 3;

    logic        clk;
    logic        reset;
    logic        run;
    opcode_t     opcode;
    funct3_t     funct3;
    logic        comparator;
    ctrl_t       ctrl;
    logic        instr_done;

    logic [15:0] lfsr_state;
    strobe_rec_t seen;
    int          mon_cycle;
    int          ir_cycle;          // First ir_en cycle, -1 if none
    int          next_cycle;        // First PC_NEXT cycle, -1 if none
    int          mismatch_errors;
    int          timeout_errors;
    int          other_errors;
    logic        timed_out;
    string       test_tag;

    cpu_controller UUT (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .opcode     (opcode),
        .funct3     (funct3),
        .comparator (comparator),
        .ctrl       (ctrl),
        .instr_done (instr_done)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Random bits
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [7:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Codes 9 to 15 give opcodes that the controller does not execute
    function automatic opcode_t pick_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:    return OPC_RTYPE;
            4'd1:    return OPC_ITYPE;
            4'd2:    return OPC_LOAD;
            4'd3:    return OPC_STORE;
            4'd4:    return OPC_BRANCH;
            4'd5:    return OPC_JAL;
            4'd6:    return OPC_JALR;
            4'd7:    return OPC_LUI;
            4'd8:    return OPC_AUIPC;
            4'd9:    return 7'h0F;   // FENCE
            4'd10:   return 7'h73;   // SYSTEM
            4'd11:   return 7'h7F;
            4'd12:   return 7'h00;
            4'd13:   return 7'h2F;   // AMO
            4'd14:   return 7'h53;   // OP-FP
            default: return 7'h07;   // LOAD-FP
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic strobe_rec_t expected_strobes(input opcode_t opc, input funct3_t f3,
                                                     input logic cmp);
        strobe_rec_t e;
        mem_size_t   size;
        e         = '0;
        e.ir_en   = 8'd1;
        e.pc_next = 8'd1;
        case (f3)
            3'b000, 3'b100: size = 3'b001;
            3'b001, 3'b101: size = 3'b010;
            3'b010:         size = 3'b100;
            default:        size = 3'b000;
        endcase
        case (opc)
            OPC_RTYPE:
                e.reg_write = 8'd1;
            OPC_ITYPE, OPC_LUI, OPC_AUIPC:
            begin
                e.reg_write  = 8'd1;
                e.wb_alu_src = 1'b1;
            end
            OPC_LOAD:
                if (size != 3'b000)
                begin
                    e.mem_read    = 8'd1;
                    e.mem_size    = size;
                    e.mem_alu_src = 1'b1;
                    e.reg_write   = 8'd1;
                    e.wb_sel      = WB_MEM;
                    e.wb_alu_src  = 1'b1;
                end
            OPC_STORE:
                if (size != 3'b000 && !f3[2])   // No unsigned stores
                begin
                    e.mem_write   = 8'd1;
                    e.mem_size    = size;
                    e.mem_alu_src = 1'b1;
                end
            OPC_BRANCH:
                e.pc_branch = {7'd0, cmp};
            OPC_JAL:
            begin
                e.reg_write = 8'd1;
                e.wb_sel    = WB_LINK;
                e.pc_jal    = 8'd1;
            end
            OPC_JALR:
            begin
                e.reg_write  = 8'd1;
                e.wb_sel     = WB_LINK;
                e.wb_alu_src = 1'b1;
                e.pc_jalr    = 8'd1;
            end
            default:
                ;                   // Fetch and advance only
        endcase
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Strobe monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (run && !reset)
        begin
            mon_cycle = mon_cycle + 1;
            if (ctrl.ir_en)
            begin
                seen.ir_en = seen.ir_en + 1;
                if (ir_cycle < 0)
                    ir_cycle = mon_cycle;
            end
            if (ctrl.pc_en)
            begin
                case (ctrl.pc_sel)
                    PC_NEXT:
                    begin
                        seen.pc_next = seen.pc_next + 1;
                        if (next_cycle < 0)
                            next_cycle = mon_cycle;
                    end
                    PC_BRANCH: seen.pc_branch = seen.pc_branch + 1;
                    PC_JAL:    seen.pc_jal = seen.pc_jal + 1;
                    default:   seen.pc_jalr = seen.pc_jalr + 1;
                endcase
            end
            if (ctrl.reg_write)
            begin
                seen.reg_write  = seen.reg_write + 1;
                seen.wb_sel     = ctrl.wb_sel;
                seen.wb_alu_src = ctrl.alu_src;
            end
            if (ctrl.mem_read)
                seen.mem_read = seen.mem_read + 1;
            if (ctrl.mem_write)
                seen.mem_write = seen.mem_write + 1;
            if (ctrl.mem_read || ctrl.mem_write)
            begin
                seen.mem_size    = ctrl.mem_size;
                seen.mem_alu_src = ctrl.alu_src;
            end
        end
    end

    task automatic clear_monitor();
        seen       = '0;
        mon_cycle  = 0;
        ir_cycle   = -1;
        next_cycle = -1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks and waits
    //////////////////////////////////////////////////////////////////////

    task automatic compare_field(input string field, input int exp, input int act);
        if (exp != act)
        begin
            mismatch_errors++;
            $display("mismatch %s %s: expected %0d, actual %0d", test_tag, field, exp, act);
        end
    endtask

    task automatic check_idle(input string where);
        if (ctrl !== CTRL_IDLE || instr_done !== 1'b0)
        begin
            mismatch_errors++;
            $display("mismatch %s idle outputs: expected %h, actual %h", where,
                     {CTRL_IDLE, 1'b0}, {ctrl, instr_done});
        end
    endtask

    task automatic wait_for_done(input logic level);
        int n;
        n = 0;
        while (instr_done !== level && n < 100)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (instr_done !== level)
        begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("timeout in %s: instr_done did not %s within 100 cycles", test_tag,
                     level ? "rise" : "fall");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int          n;
        int          k;
        logic [7:0]  bits;
        strobe_rec_t exp_rec;
        clk             = 1'b0;
        reset           = 1'b1;
        run             = 1'b0;
        opcode          = '0;
        funct3          = '0;
        comparator      = 1'b0;
        lfsr_state      = 16'd41452;
        mismatch_errors = 0;
        timeout_errors  = 0;
        other_errors    = 0;
        timed_out       = 1'b0;
        test_tag        = "reset";
        clear_monitor();

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (k = 0; k < 3; k++)
        begin
            @(posedge clk);
            #1;
            check_idle("after reset");
        end

        for (n = 0; n < 300; n++)
        begin
            draw_bits(4, bits);
            opcode = pick_opcode(bits[3:0]);
            draw_bits(3, bits);
            funct3 = bits[2:0];
            draw_bits(1, bits);
            comparator = bits[0];
            test_tag = $sformatf("instr %0d (opcode %h funct3 %0d cmp %0d)", n, opcode,
                                 funct3, comparator);
            check_idle(test_tag);
            clear_monitor();
            run = 1'b1;

            wait_for_done(1'b1);
            if (timed_out)
                break;
            // Back-pressure: done must hold while run stays high
            for (k = 0; k < 2; k++)
            begin
                @(posedge clk);
                #1;
                if (instr_done !== 1'b1)
                begin
                    other_errors++;
                    $display("%s: instr_done dropped while run was still high", test_tag);
                end
            end
            run = 1'b0;
            wait_for_done(1'b0);
            if (timed_out)
                break;

            exp_rec = expected_strobes(opcode, funct3, comparator);
            compare_field("ir_en count", exp_rec.ir_en, seen.ir_en);
            compare_field("PC_NEXT count", exp_rec.pc_next, seen.pc_next);
            compare_field("fetch cycle", FETCH_CYCLE, ir_cycle);
            compare_field("advance cycle", ADVANCE_CYCLE, next_cycle);
            compare_field("PC_BRANCH count", exp_rec.pc_branch, seen.pc_branch);
            compare_field("PC_JAL count", exp_rec.pc_jal, seen.pc_jal);
            compare_field("PC_JALR count", exp_rec.pc_jalr, seen.pc_jalr);
            compare_field("reg_write count", exp_rec.reg_write, seen.reg_write);
            compare_field("mem_read count", exp_rec.mem_read, seen.mem_read);
            compare_field("mem_write count", exp_rec.mem_write, seen.mem_write);
            compare_field("mem_size", exp_rec.mem_size, seen.mem_size);
            compare_field("alu_src at memory strobe", exp_rec.mem_alu_src, seen.mem_alu_src);
            compare_field("wb_sel at reg_write", exp_rec.wb_sel, seen.wb_sel);
            compare_field("alu_src at reg_write", exp_rec.wb_alu_src, seen.wb_alu_src);
        end

        $display("errors: %0d mismatch, %0d timeout, %0d other", mismatch_errors,
                 timeout_errors, other_errors);
        if (mismatch_errors == 0 && timeout_errors == 0 && other_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
rv_isa_pkg.sv
ctrl_pkg.sv
instr_sequencer.sv
reg_writeback_unit.sv
mem_access_unit.sv
flow_change_unit.sv
cpu_controller.sv
tb_cpu_controller.sv
